// ==== all.f ====
pcs_cgmii_pkg.sv
pcs_block_pkg.sv
pcs_block_encoder.sv
pcs_tx_sequencer.sv
pcs_scrambler.sv
pcs_tx_top.sv
pcs_tx_properties.sv
pcs_tx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the transmit PCS testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module pcs_tx_tb -f all.f -o sim_pcs_tx
./obj_dir/sim_pcs_tx | tee sim.log

if grep -q "Verification failed" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
echo "Simulation finished without a reported failure"
exit 0

// ==== pcs_tx_tb.sv ====
// ======================================================================
// Testbench for the transmit PCS top level
// Drives random CGMII frames, ordered sets, gaps and faults, predicts
// every scrambled block with a model and checks it on the output side
// ======================================================================

`timescale 1ns/1ps

module pcs_tx_tb;

	import pcs_cgmii_pkg::*;
	import pcs_block_pkg::*;

	localparam int FRAME_MAX = 8;
	localparam int N_OS      = 40;
	localparam int N_FIXED   = 40;
	localparam int N_RAND    = 30;
	localparam int WORD_BUDGET = N_OS + 16*FRAME_MAX + N_FIXED + N_RAND*(FRAME_MAX + 1);
	localparam pcs_block_t ERR_BLK = {SH_CTRL, BT_CTRL, {8{PCS_ERROR}}};

	logic        clock = 1'b0;
	logic        reset;
	logic        valid_in;
	cgmii_word_t word_in;
	logic        break_sh;
	logic        valid_out;
	pcs_block_t  block_out;

	int          seed = 17278;
	int          errors = 0;
	int          checks = 0;
	int          test_err = 0;
	logic        gap_on = 1'b0;
	logic        brk = 1'b0;
	logic [2:0]  vhist = 3'b000;
	tx_state_e   m_state = ST_INIT;
	logic [57:0] m_scr = '1;
	pcs_block_t  exp_q[$];

	pcs_tx_top pcs_tx_top_inst (
		.i_clock         (clock),
		.i_reset         (reset),
		.i_valid         (valid_in),
		.i_word          (word_in),
		.i_break_data_sh (break_sh),
		.o_valid         (valid_out),
		.o_block         (block_out)
	);

	always #10 clock = ~clock;

	// The output valid repeats this input valid history three cycles later
	always @(posedge clock)
	begin
		vhist <= reset ? 3'b000 : {vhist[1:0], valid_in};
	end

	function automatic logic [63:0] rand64();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = $random(seed);
		lo = $random(seed);
		return {hi, lo};
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	task automatic check_block(input string name, input pcs_block_t got, input pcs_block_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	// 64b/66b encoding table with lane 0 in the top byte
	task automatic encode_word(input cgmii_word_t w, input logic brk_sh,
		output tx_type_e t, output pcs_block_t b);
		logic [7:0] lane [8];
		logic [7:0] term_bt [8];
		logic       fill_ok;
		term_bt = '{BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
			BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7};
		for (int j = 0; j < 8; j++)
			lane[j] = w.data[63 - 8*j -: 8];
		t = TYPE_E;
		b = ERR_BLK;
		if (w.ctrl == 8'h00)
		begin
			t = TYPE_D;
			b = {brk_sh ? 2'b11 : SH_DATA, w.data};
		end
		else if (w.ctrl == 8'h80 && lane[0] == CGMII_START)
		begin
			t = TYPE_S;
			b = {SH_CTRL, BT_START, w.data[55:0]};
		end
		else if (w.ctrl == 8'h80 && (lane[0] == CGMII_SEQ || lane[0] == CGMII_FSIG))
		begin
			t = TYPE_C;
			b = {SH_CTRL, BT_ORDER, lane[1], lane[2], lane[3],
				(lane[0] == CGMII_FSIG) ? PCS_O_FSIG : PCS_O_SEQ, 28'd0};
		end
		else if (w.ctrl == 8'hFF && w.data == {8{CGMII_IDLE}})
		begin
			t = TYPE_C;
			b = {SH_CTRL, BT_CTRL, 56'd0};
		end
		else
		begin
			for (int k = 0; k < 8; k++)
			begin
				fill_ok = (w.ctrl == (8'hFF >> k)) && (lane[k] == CGMII_TERMINATE);
				for (int j = k + 1; j < 8; j++)
					fill_ok = fill_ok && (lane[j] == CGMII_IDLE || lane[j] == CGMII_ERROR);
				if (fill_ok)
				begin
					t = TYPE_T;
					b = {SH_CTRL, term_bt[k], 56'd0};
					for (int j = 0; j < k; j++)
						b.payload[55 - 8*j -: 8] = lane[j];
					// Codes of the fill lanes are packed at the bottom
					for (int j = k + 1; j < 8; j++)
						b.payload[7*(7 - j) + 6 -: 7] =
							(lane[j] == CGMII_IDLE) ? PCS_IDLE : PCS_ERROR;
				end
			end
		end
	endtask

	// Encoder, transmit FSM and scrambler for one accepted word
	task automatic model_word(input cgmii_word_t w, input logic brk_sh);
		tx_type_e   t;
		pcs_block_t b;
		logic       legal;
		logic       ob;
		encode_word(w, brk_sh, t, b);
		legal = (m_state == ST_D) ? (t == TYPE_D || t == TYPE_T) : (t == TYPE_C || t == TYPE_S);
		if (!legal)
		begin
			m_state = ST_E;
			b = ERR_BLK;
		end
		else
			m_state = (t == TYPE_C || t == TYPE_T) ? ST_C : ST_D;
		for (int i = 63; i >= 0; i--)
		begin
			ob = b.payload[i] ^ m_scr[38] ^ m_scr[57];
			b.payload[i] = ob;
			m_scr = {m_scr[56:0], ob};
		end
		exp_q.push_back(b);
	endtask

	function automatic cgmii_word_t idle_word();
		return '{data: {8{CGMII_IDLE}}, ctrl: 8'hFF};
	endfunction

	function automatic cgmii_word_t os_word();
		logic [63:0] r;
		r = rand64();
		return '{data: {r[0] ? CGMII_FSIG : CGMII_SEQ, r[31:8], 32'd0}, ctrl: 8'h80};
	endfunction

	function automatic cgmii_word_t start_word();
		logic [63:0] r;
		r = rand64();
		return '{data: {CGMII_START, r[55:0]}, ctrl: 8'h80};
	endfunction

	function automatic cgmii_word_t data_word();
		return '{data: rand64(), ctrl: 8'h00};
	endfunction

	// Terminate at lane k with a mix of IDLE and ERROR in later lanes
	function automatic cgmii_word_t term_word(input int k);
		cgmii_word_t w;
		logic [63:0] r;
		r = rand64();
		w.data = r;
		w.ctrl = 8'hFF >> k;
		w.data[63 - 8*k -: 8] = CGMII_TERMINATE;
		for (int j = k + 1; j < 8; j++)
			w.data[63 - 8*j -: 8] = r[j] ? CGMII_ERROR : CGMII_IDLE;
		return w;
	endfunction

	task automatic send(input cgmii_word_t w);
		if (gap_on && rand_below(4) == 0)
		begin
			@(posedge clock);
			#2;
			valid_in = 1'b0;
			word_in  = {rand64(), 8'hA5};
		end
		@(posedge clock);
		#2;
		valid_in = 1'b1;
		word_in  = w;
		break_sh = brk;
		model_word(w, brk);
	endtask

	task automatic send_frame(input int k);
		send(start_word());
		repeat (1 + rand_below(4)) send(data_word());
		send(term_word(k));
		repeat (1 + rand_below(2)) send(idle_word());
	endtask

	task automatic finish_test(input string name);
		@(posedge clock);
		#2;
		valid_in = 1'b0;
		while (exp_q.size() != 0)
			@(posedge clock);
		repeat (3) @(posedge clock);
		$display("test %-14s done, %0d errors", name, errors - test_err);
		test_err = errors;
	endtask

	// Outputs are sampled on the falling edge away from all updates
	always @(negedge clock)
	begin
		check_valid("o_valid", valid_out, vhist[2]);
		if (valid_out === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("ERROR: a block left the DUT while none was expected");
			end
			else
				check_block("o_block", block_out, exp_q.pop_front());
		end
	end

	initial
	begin
		#((2*WORD_BUDGET + 100) * 20);
		$display("ERROR: timeout, the expected blocks did not all arrive");
		$display("Verification failed");
		$finish;
	end

	initial
	begin
		cgmii_word_t w;
		logic [7:0]  bad;
		reset    = 1'b1;
		valid_in = 1'b0;
		word_in  = '0;
		break_sh = 1'b0;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		repeat (N_OS) send(rand_below(3) == 0 ? idle_word() : os_word());
		finish_test("idle_os");

		gap_on = 1'b1;
		for (int k = 0; k < 8; k++)
			send_frame(k);
		finish_test("term_lanes");

		// Data after idle, start inside a frame, terminate after idle
		send(idle_word());
		send(data_word());
		send(idle_word());
		send(start_word());
		send(data_word());
		send(start_word());
		send(data_word());
		send(term_word(3));
		send(term_word(5));
		send(idle_word());
		send(data_word());
		send(start_word());
		send(term_word(0));
		send(idle_word());
		finish_test("illegal_order");

		for (int i = 0; i < 4; i++)
		begin
			w = idle_word();
			bad = 8'(rand64());
			if (bad == CGMII_IDLE)
				bad = 8'hAA;
			w.data[55 - 8*rand_below(7) -: 8] = bad;
			send(w);
			send(start_word());
			// Lane 7 holds data where only IDLE or ERROR may stand
			w = term_word(i);
			w.data[7:0] = 8'h55;
			send(w);
			send(start_word());
			w = data_word();
			w.ctrl = 8'h01;
			send(w);
			send(idle_word());
		end
		finish_test("invalid_chars");

		for (int k = 0; k < 8; k++)
		begin
			brk = ~brk;
			send_frame(k);
		end
		brk = 1'b0;
		finish_test("break_sh");

		for (int i = 0; i < N_RAND; i++)
		begin
			if (rand_below(8) == 0)
				send(data_word());
			send_frame(rand_below(8));
		end
		finish_test("random_frames");

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== pcs_tx_properties.sv ====
// ======================================================================
// Concurrent assertions on the transmit PCS top level
// Bound into pcs_tx_top, covers latency, sync headers and reset
// ======================================================================

`timescale 1ns/1ps

module pcs_tx_properties
(
	input logic                       i_clock,
	input logic                       i_reset,
	input logic                       i_valid,
	input logic                       i_break_data_sh,
	input logic                       o_valid,
	input pcs_block_pkg::pcs_block_t  o_block
);

	import pcs_block_pkg::*;

	// Three register stages from word to block
	a_latency: assert property (@(posedge i_clock) disable iff (i_reset)
		o_valid == $past(i_valid, 3))
		else $error("o_valid is not i_valid delayed by 3 cycles");

	// Header 11 only comes from the fault input
	a_sync_header: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_valid && !$past(i_break_data_sh, 3)) |-> (o_block.sh == SH_DATA || o_block.sh == SH_CTRL))
		else $error("illegal sync header on a valid block");

	a_reset_valid: assert property (@(posedge i_clock) i_reset |=> !o_valid)
		else $error("o_valid high during reset");

endmodule

bind pcs_tx_top pcs_tx_properties pcs_tx_properties_inst (
	.i_clock         (i_clock),
	.i_reset         (i_reset),
	.i_valid         (i_valid),
	.i_break_data_sh (i_break_data_sh),
	.o_valid         (o_valid),
	.o_block         (o_block)
);

// ==== pcs_tx_top.sv ====
// ======================================================================
// Transmit PCS top level, CGMII words in, scrambled 66-bit blocks out
// Encoder, transmit FSM and scrambler in a chain, three cycles from
// i_valid to o_valid, one word accepted every cycle
// ======================================================================

`timescale 1ns/1ps

module pcs_tx_top
(
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_valid,
	input  pcs_cgmii_pkg::cgmii_word_t i_word,
	input  logic                       i_break_data_sh,
	output logic                       o_valid,
	output pcs_block_pkg::pcs_block_t  o_block
);

	import pcs_block_pkg::*;

	logic       enc_valid;
	tx_type_e   enc_type;
	pcs_block_t enc_block;
	logic       seq_valid;
	pcs_block_t seq_block;

	pcs_block_encoder pcs_block_encoder_inst (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_valid         (i_valid),
		.i_word          (i_word),
		.i_break_data_sh (i_break_data_sh),
		.o_valid         (enc_valid),
		.o_type          (enc_type),
		.o_block         (enc_block)
	);

	pcs_tx_sequencer pcs_tx_sequencer_inst (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (enc_valid),
		.i_type  (enc_type),
		.i_block (enc_block),
		.o_valid (seq_valid),
		.o_block (seq_block)
	);

	pcs_scrambler pcs_scrambler_inst (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_valid (seq_valid),
		.i_block (seq_block),
		.o_valid (o_valid),
		.o_block (o_block)
	);

endmodule

// ==== pcs_scrambler.sv ====
// ======================================================================
// Self-synchronizing scrambler, polynomial 1 + x^39 + x^58
// Scrambles the 64 payload bits from bit 63 down to bit 0 and passes
// the sync header through. State advances on valid blocks only
// ======================================================================

`timescale 1ns/1ps

module pcs_scrambler
(
	input  logic                      i_clock,
	input  logic                      i_reset,
	input  logic                      i_valid,
	input  pcs_block_pkg::pcs_block_t i_block,
	output logic                      o_valid,
	output pcs_block_pkg::pcs_block_t o_block
);

	import pcs_block_pkg::*;

	logic [57:0] scr_state;
	logic [57:0] scr_next;
	logic [63:0] scr_payload;
	logic        valid_q;
	pcs_block_t  block_q;

	// Bit-serial form unrolled over one block
	always_comb
	begin
		scr_next = scr_state;
		for (int i = 63; i >= 0; i--)
		begin
			scr_payload[i] = i_block.payload[i] ^ scr_next[38] ^ scr_next[57];
			scr_next       = {scr_next[56:0], scr_payload[i]};
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			scr_state <= '1;
			valid_q   <= 1'b0;
		end
		else
		begin
			valid_q <= i_valid;
			if (i_valid)
			begin
				scr_state <= scr_next;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			block_q.sh      <= i_block.sh;
			block_q.payload <= scr_payload;
		end
	end

	assign o_valid = valid_q;
	assign o_block = block_q;

endmodule

// ==== pcs_tx_sequencer.sv ====
// ======================================================================
// Transmit FSM of the PCS
// Checks each encoded block against the current state and replaces
// out-of-order or unrecognized blocks with the error block.
// One register stage between the encoder and the scrambler
// ======================================================================

`timescale 1ns/1ps

module pcs_tx_sequencer
(
	input  logic                      i_clock,
	input  logic                      i_reset,
	input  logic                      i_valid,
	input  pcs_block_pkg::tx_type_e   i_type,
	input  pcs_block_pkg::pcs_block_t i_block,
	output logic                      o_valid,
	output pcs_block_pkg::pcs_block_t o_block
);

	import pcs_block_pkg::*;

	tx_state_e  state;
	tx_state_e  state_next;
	logic       legal;
	logic       valid_q;
	pcs_block_t block_q;

	// Legal classes per state
	always_comb
	begin
		case (state)
			ST_D:
			begin
				legal = (i_type == TYPE_D) || (i_type == TYPE_T);
			end
			default:
			begin
				// ST_INIT, ST_C and ST_E wait for a control or start block
				legal = (i_type == TYPE_C) || (i_type == TYPE_S);
			end
		endcase
	end

	always_comb
	begin
		if (!legal)
		begin
			state_next = ST_E;
		end
		else if ((i_type == TYPE_C) || (i_type == TYPE_T))
		begin
			state_next = ST_C;
		end
		else
		begin
			state_next = ST_D;
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			state   <= ST_INIT;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= i_valid;
			if (i_valid)
			begin
				state <= state_next;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			block_q <= legal ? i_block : ERROR_BLOCK;
		end
	end

	assign o_valid = valid_q;
	assign o_block = block_q;

endmodule

// ==== pcs_block_encoder.sv ====
// ======================================================================
// 64b/66b block encoder, first stage of the transmit PCS
// Registers each valid CGMII word, classifies it as data, start,
// control or terminate and forms the unscrambled 66-bit block.
// Class and block are combinational from the word register
// ======================================================================

`timescale 1ns/1ps

module pcs_block_encoder
(
	input  logic                       i_clock,
	input  logic                       i_reset,
	input  logic                       i_valid,
	input  pcs_cgmii_pkg::cgmii_word_t i_word,
	input  logic                       i_break_data_sh,
	output logic                       o_valid,
	output pcs_block_pkg::tx_type_e    o_type,
	output pcs_block_pkg::pcs_block_t  o_block
);

	import pcs_cgmii_pkg::*;
	import pcs_block_pkg::*;

	cgmii_word_t     word_q;
	logic            valid_q;
	logic            break_q;
	logic [7:0]      lane0;
	logic [1:0]      data_sh;
	logic [3:0]      os_code;

	// Index 6 is lane 1, so a slice keeps lane order top down
	logic [6:0][6:0] pcs_code;
	logic [6:0]      fill_ok;

	// term_hit[k] means terminate at lane k
	logic [7:0]      term_hit;
	logic [2:0]      term_lane;

	tx_type_e        blk_type;
	pcs_block_t      blk;

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= i_valid;
		end
	end

	// The fault flag is captured with its word and stays aligned with it
	always_ff @(posedge i_clock)
	begin
		if (i_valid)
		begin
			word_q  <= i_word;
			break_q <= i_break_data_sh;
		end
	end

	assign lane0   = word_q.data[63 -: 8];
	assign data_sh = break_q ? 2'b11 : SH_DATA;
	assign os_code = (lane0 == CGMII_FSIG) ? PCS_O_FSIG : PCS_O_SEQ;

	// Map lanes 1 to 7 to PCS codes
	// Only IDLE and ERROR are legal fill
	always_comb
	begin
		for (int j = 1; j < 8; j++)
		begin
			case (word_q.data[63 - 8*j -: 8])
				CGMII_IDLE:
				begin
					pcs_code[7-j] = PCS_IDLE;
					fill_ok[7-j]  = 1'b1;
				end
				CGMII_ERROR:
				begin
					pcs_code[7-j] = PCS_ERROR;
					fill_ok[7-j]  = 1'b1;
				end
				default:
				begin
					pcs_code[7-j] = PCS_ERROR;
					fill_ok[7-j]  = 1'b0;
				end
			endcase
		end
	end

	// Terminate at lane k needs ctrl FF >> k and legal fill after lane k
	always_comb
	begin
		term_lane = 3'd0;
		for (int k = 0; k < 8; k++)
		begin
			term_hit[k] = (word_q.ctrl == (8'hFF >> k)) &&
				(word_q.data[63 - 8*k -: 8] == CGMII_TERMINATE);
			for (int j = k + 1; j < 8; j++)
			begin
				term_hit[k] = term_hit[k] && fill_ok[7-j];
			end
			if (term_hit[k])
			begin
				term_lane = 3'(k);
			end
		end
	end

	always_comb
	begin
		blk_type = TYPE_E;
		blk      = ERROR_BLOCK;
		if (word_q.ctrl == 8'h00)
		begin
			blk_type    = TYPE_D;
			blk.sh      = data_sh;
			blk.payload = word_q.data;
		end
		else if ((word_q.ctrl == 8'h80) && (lane0 == CGMII_START))
		begin
			blk_type    = TYPE_S;
			blk.payload = {BT_START, word_q.data[55:0]};
		end
		else if ((word_q.ctrl == 8'h80) && ((lane0 == CGMII_SEQ) || (lane0 == CGMII_FSIG)))
		begin
			// Lanes 1 to 3 carry the ordered set and the rest is zero
			blk_type    = TYPE_C;
			blk.payload = {BT_ORDER, word_q.data[55 -: 24], os_code, 28'd0};
		end
		else if ((word_q.ctrl == 8'hFF) && (word_q.data == {8{CGMII_IDLE}}))
		begin
			blk_type    = TYPE_C;
			blk.payload = {BT_CTRL, {8{PCS_IDLE}}};
		end
		else if (|term_hit)
		begin
			blk_type = TYPE_T;
			case (term_lane)
				3'd0: blk.payload = {BT_TERM0, 7'd0, pcs_code[6:0]};
				3'd1: blk.payload = {BT_TERM1, word_q.data[63 -: 8], 6'd0, pcs_code[5:0]};
				3'd2: blk.payload = {BT_TERM2, word_q.data[63 -: 16], 5'd0, pcs_code[4:0]};
				3'd3: blk.payload = {BT_TERM3, word_q.data[63 -: 24], 4'd0, pcs_code[3:0]};
				3'd4: blk.payload = {BT_TERM4, word_q.data[63 -: 32], 3'd0, pcs_code[2:0]};
				3'd5: blk.payload = {BT_TERM5, word_q.data[63 -: 40], 2'd0, pcs_code[1:0]};
				3'd6: blk.payload = {BT_TERM6, word_q.data[63 -: 48], 1'b0, pcs_code[0]};
				default: blk.payload = {BT_TERM7, word_q.data[63 -: 56]};
			endcase
		end
	end

	assign o_valid = valid_q;
	assign o_type  = blk_type;
	assign o_block = blk;

endmodule

// ==== pcs_block_pkg.sv ====
// ======================================================================
// 64b/66b block definitions for the 100GBASE-R transmit PCS
// Sync headers, block type field values, the 66-bit block, the block
// class enum from the encoder and the transmit FSM state enum
// ======================================================================

package pcs_block_pkg;

	// Sync headers
	localparam logic [1:0] SH_DATA = 2'b01;
	localparam logic [1:0] SH_CTRL = 2'b10;

	// Block type field of control blocks
	localparam logic [7:0] BT_CTRL  = 8'h78;
	localparam logic [7:0] BT_START = 8'h1E;
	localparam logic [7:0] BT_ORDER = 8'hD2;

	// Terminate at lane 0 through lane 7
	localparam logic [7:0] BT_TERM0 = 8'hE1;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'h55;
	localparam logic [7:0] BT_TERM3 = 8'h2D;
	localparam logic [7:0] BT_TERM4 = 8'h33;
	localparam logic [7:0] BT_TERM5 = 8'h4B;
	localparam logic [7:0] BT_TERM6 = 8'h87;
	localparam logic [7:0] BT_TERM7 = 8'hFF;

	typedef struct packed {
		logic [1:0]  sh;
		logic [63:0] payload;
	} pcs_block_t;

	// Block class as seen by the transmit FSM
	// TYPE_E is a word that fits no legal pattern
	typedef enum logic [2:0] {
		TYPE_D,
		TYPE_S,
		TYPE_C,
		TYPE_T,
		TYPE_E
	} tx_type_e;

	typedef enum logic [2:0] {
		ST_INIT,
		ST_C,
		ST_D,
		ST_E
	} tx_state_e;

	// Control block made of eight error codes
	localparam pcs_block_t ERROR_BLOCK = '{
		sh:      SH_CTRL,
		payload: {BT_CTRL, {8{pcs_cgmii_pkg::PCS_ERROR}}}
	};

endpackage

// ==== pcs_cgmii_pkg.sv ====
// ======================================================================
// CGMII side definitions for the 100GBASE-R transmit PCS
// Control characters seen on CGMII, the PCS codes they map to and
// the 72-bit CGMII word that carries data and control bits together
// Modules import it inside their body and name its types in port lists
// ======================================================================

package pcs_cgmii_pkg;

	// CGMII control characters
	localparam logic [7:0] CGMII_START     = 8'hFB;
	localparam logic [7:0] CGMII_TERMINATE = 8'hFD;
	localparam logic [7:0] CGMII_SEQ       = 8'h9C;
	localparam logic [7:0] CGMII_FSIG      = 8'h5C;
	localparam logic [7:0] CGMII_IDLE      = 8'h07;
	localparam logic [7:0] CGMII_ERROR     = 8'hFE;

	// 7-bit PCS control codes
	localparam logic [6:0] PCS_IDLE  = 7'h00;
	localparam logic [6:0] PCS_ERROR = 7'h1E;

	// 4-bit O codes of ordered-set blocks
	localparam logic [3:0] PCS_O_SEQ  = 4'h0;
	localparam logic [3:0] PCS_O_FSIG = 4'hF;

	// One CGMII transfer
	// Lane 0 sits in data[63:56] and is flagged by ctrl[7]
	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  ctrl;
	} cgmii_word_t;

endpackage
